//--- common/bpu_pkg.sv
// ######################################################################
// bpu_pkg: shared types for the branch prediction unit
// branch kinds, table entries, correction and prediction packets,
// plus the 2-bit saturating counter step
// ######################################################################

package bpu_pkg;

    // stored tag field, wider than any tag in use
    localparam int TAG_FIELD_W = 16;

    // branch kind, as seen by the BTB and the back end
    typedef enum logic [2:0] {
        NONE = 3'd0,  // not a branch
        COND = 3'd1,  // conditional, direction from PHT
        JUMP = 3'd2,  // direct or indirect jump
        CALL = 3'd3,  // pushes return address
        RET  = 3'd4   // target from RAS top
    } br_type_e;

    // msb set = predict taken
    typedef logic [1:0] scnt_t;

    // one BTB entry, 52 bits
    typedef struct packed {
        logic                   valid;
        logic [TAG_FIELD_W-1:0] tag;      // zero extended
        logic [31:0]            target;
        br_type_e               br_type;
    } btb_entry_t;

    // resolved branch from the back end
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] target;       // resolved target
        br_type_e    br_type;
        logic        taken;
        logic        mispredict;   // redirect fetch
        logic [31:0] redirect_pc;  // correct next fetch address
    } correct_info_t;

    // packet to the fetch queue
    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;        // one bit per slot
        logic        taken;
        logic        taken_slot;  // 0 or 1, valid with taken
        br_type_e    br_type;
        logic [31:0] npc;
    } predict_info_t;

    // lookup result for one slot
    typedef struct packed {
        logic        hit;
        br_type_e    br_type;
        logic [31:0] target;
        scnt_t       scnt;
    } slot_pred_t;

    // step toward taken or not taken, saturating at 0 and 3
    function automatic scnt_t next_scnt(input scnt_t cnt, input logic taken);
        scnt_t nxt;
        nxt = cnt;
        if (taken) begin
            if (cnt != 2'b11) begin
                nxt = cnt + 2'b01;
            end
        end else begin
            if (cnt != 2'b00) begin
                nxt = cnt - 2'b01;
            end
        end
        return nxt;
    endfunction

endpackage

//--- design/bpu_btb.sv
// ######################################################################
// bpu_btb: two-bank tagged branch target buffer
// one lookup per slot each cycle, one write per correction
// ######################################################################
`timescale 1ns/100ps

module bpu_btb #(
    parameter int BTB_IDX_W = 8,
    parameter int TAG_W     = 12
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [31:0]                 lookup_pc_i,
    input  logic                        corr_valid_i,
    input  bpu_pkg::correct_info_t      corr_info_i,
    output bpu_pkg::btb_entry_t [1:0]   btb_slot_o,
    output logic [1:0]                  hit_o
);

    localparam int DEPTH = 1 << BTB_IDX_W;
    localparam int TF_W  = bpu_pkg::TAG_FIELD_W;

    bpu_pkg::btb_entry_t mem_q [2][DEPTH];  // payload, bank = slot
    logic [DEPTH-1:0]    vld_q [2];         // per-entry valid

    logic [BTB_IDX_W-1:0] lk_idx;
    logic [TF_W-1:0]      lk_tag;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic                 wr_bank;
    logic                 wr_en;

    assign lk_idx  = lookup_pc_i[BTB_IDX_W+2:3];
    assign lk_tag  = TF_W'(lookup_pc_i[TAG_W+11:12]);  // zero extend
    assign wr_idx  = corr_info_i.pc[BTB_IDX_W+2:3];
    assign wr_bank = corr_info_i.pc[2];                // slot of the branch
    assign wr_en   = corr_valid_i && (corr_info_i.br_type != bpu_pkg::NONE);

    // read both banks, same row
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            btb_slot_o[i]       = mem_q[i][lk_idx];
            btb_slot_o[i].valid = vld_q[i][lk_idx];  // valid lives in its own vector
            hit_o[i] = btb_slot_o[i].valid
                    && (btb_slot_o[i].tag == lk_tag)
                    && (btb_slot_o[i].br_type != bpu_pkg::NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q[0] <= '0;
            vld_q[1] <= '0;
        end else if (wr_en) begin
            vld_q[wr_bank][wr_idx] <= 1'b1;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_bank][wr_idx].tag     <= TF_W'(corr_info_i.pc[TAG_W+11:12]);
            mem_q[wr_bank][wr_idx].target  <= corr_info_i.target;
            mem_q[wr_bank][wr_idx].br_type <= corr_info_i.br_type;
        end
    end

endmodule

//--- design/bpu_local_predictor.sv
// ######################################################################
// bpu_local_predictor: per-slot local history table feeding a table
// of 2-bit counters indexed by {history, pc bits}
// trained read-modify-write from back-end corrections
// ######################################################################
`timescale 1ns/100ps

module bpu_local_predictor #(
    parameter int BTB_IDX_W = 8,
    parameter int HIST_W    = 5,
    parameter int PHT_PC_W  = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [31:0]                 lookup_pc_i,
    input  logic                        corr_valid_i,
    input  bpu_pkg::correct_info_t      corr_info_i,
    output bpu_pkg::scnt_t [1:0]        scnt_o
);

    localparam int BHT_DEPTH = 1 << BTB_IDX_W;
    localparam int PHT_IDX_W = HIST_W + PHT_PC_W;
    localparam int PHT_DEPTH = 1 << PHT_IDX_W;

    logic [HIST_W-1:0] bht_q [2][BHT_DEPTH];  // bank = slot
    bpu_pkg::scnt_t    pht_q [2][PHT_DEPTH];

    // lookup side
    logic [BTB_IDX_W-1:0]    lk_idx;
    logic [HIST_W-1:0]       lk_hist [2];
    logic [PHT_IDX_W-1:0]    lk_pht_idx [2];

    // training side
    logic                    c_bank;
    logic [BTB_IDX_W-1:0]    c_idx;
    logic [HIST_W-1:0]       c_hist;       // history before this branch
    logic [PHT_IDX_W-1:0]    c_pht_idx;
    bpu_pkg::scnt_t          c_cnt;
    bpu_pkg::scnt_t          c_cnt_nxt;
    logic [HIST_W-1:0]       c_hist_nxt;
    logic                    c_upd;

    assign lk_idx = lookup_pc_i[BTB_IDX_W+2:3];

    // history first, then counter
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lk_hist[i]    = bht_q[i][lk_idx];
            lk_pht_idx[i] = {lk_hist[i], lookup_pc_i[PHT_PC_W+2:3]};
            scnt_o[i]     = pht_q[i][lk_pht_idx[i]];
        end
    end

    assign c_bank     = corr_info_i.pc[2];
    assign c_idx      = corr_info_i.pc[BTB_IDX_W+2:3];
    assign c_hist     = bht_q[c_bank][c_idx];
    assign c_pht_idx  = {c_hist, corr_info_i.pc[PHT_PC_W+2:3]};  // old history index
    assign c_cnt      = pht_q[c_bank][c_pht_idx];
    assign c_cnt_nxt  = bpu_pkg::next_scnt(c_cnt, corr_info_i.taken);
    assign c_hist_nxt = {c_hist[HIST_W-2:0], corr_info_i.taken};  // newest in lsb
    assign c_upd      = corr_valid_i && (corr_info_i.br_type == bpu_pkg::COND);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < BHT_DEPTH; e++) begin
                    bht_q[b][e] <= '0;
                end
                for (int e = 0; e < PHT_DEPTH; e++) begin
                    pht_q[b][e] <= '0;  // strongly not taken
                end
            end
        end else if (c_upd) begin
            bht_q[c_bank][c_idx]     <= c_hist_nxt;
            pht_q[c_bank][c_pht_idx] <= c_cnt_nxt;
        end
    end

endmodule

//--- design/bpu_out_stage.sv
// ######################################################################
// bpu_out_stage: one-entry output register toward the fetch queue
// valid/ready handshake, cleared by a mispredict flush
// ######################################################################
`timescale 1ns/100ps

module bpu_out_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bpu_pkg::predict_info_t      pred_i,
    input  logic                        flush_i,
    input  logic                        pred_ready_i,
    output logic                        accept_o,
    output logic                        pred_valid_o,
    output bpu_pkg::predict_info_t      pred_info_o
);

    logic                   valid_q;
    bpu_pkg::predict_info_t info_q;

    // empty, or draining this cycle
    assign accept_o     = !valid_q || pred_ready_i;
    assign pred_valid_o = valid_q;
    assign pred_info_o  = info_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // drop held packet, even under stall
        end else if (accept_o) begin
            valid_q <= 1'b1;  // pc stage always offers a packet
        end
    end

    // payload holds while stalled
    always_ff @(posedge clk) begin
        if (accept_o && !flush_i) begin
            info_q <= pred_i;
        end
    end

endmodule

//--- design/bpu_pc_stage.sv
// ######################################################################
// bpu_pc_stage: fetch pc register and the per-cycle prediction
// slot mask, taken slot selection and next pc choice
// ######################################################################
`timescale 1ns/100ps

module bpu_pc_stage #(
    parameter logic [31:0] INIT_PC = 32'h1c00_0000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        accept_i,
    input  logic                        corr_valid_i,
    input  bpu_pkg::correct_info_t      corr_info_i,
    input  bpu_pkg::btb_entry_t [1:0]   btb_slot_i,
    input  logic [1:0]                  hit_i,
    input  bpu_pkg::scnt_t [1:0]        scnt_i,
    input  logic [31:0]                 ras_top_i,
    output logic [31:0]                 pc_o,
    output bpu_pkg::predict_info_t      pred_o
);

    logic [31:0]              pc_q;
    logic [31:0]              npc;
    logic [31:0]              seq_pc;      // aligned pc + 8
    bpu_pkg::slot_pred_t [1:0] slot;
    logic [1:0]               slot_tk;     // per-slot taken
    logic                     win0;
    logic                     win1;
    logic                     redirect;

    assign pc_o     = pc_q;
    assign redirect = corr_valid_i && corr_info_i.mispredict;
    assign seq_pc   = {pc_q[31:3], 3'b000} + 32'd8;

    // gather table outputs per slot
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            slot[i].hit     = hit_i[i];
            slot[i].br_type = btb_slot_i[i].br_type;
            slot[i].target  = btb_slot_i[i].target;
            slot[i].scnt    = scnt_i[i];
            // non-COND hits are always taken
            slot_tk[i] = slot[i].hit
                      && ((slot[i].br_type != bpu_pkg::COND) || slot[i].scnt[1]);
        end
    end

    assign win0 = !pc_q[2] && slot_tk[0];  // slot 0 only when pc is 8-aligned
    assign win1 = !win0 && slot_tk[1];

    always_comb begin
        pred_o.pc         = pc_q;
        pred_o.mask       = {!win0, !pc_q[2]};
        pred_o.taken      = win0 || win1;
        pred_o.taken_slot = win1;
        pred_o.br_type    = bpu_pkg::NONE;
        npc               = seq_pc;
        if (win0) begin
            pred_o.br_type = slot[0].br_type;
            npc = (slot[0].br_type == bpu_pkg::RET) ? ras_top_i : slot[0].target;
        end else if (win1) begin
            pred_o.br_type = slot[1].br_type;
            npc = (slot[1].br_type == bpu_pkg::RET) ? ras_top_i : slot[1].target;
        end
        pred_o.npc = npc;
    end

    // redirect beats accept beats hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= INIT_PC;
        end else if (redirect) begin
            pc_q <= corr_info_i.redirect_pc;
        end else if (accept_i) begin
            pc_q <= npc;
        end
    end

endmodule

//--- design/bpu_ras.sv
// ######################################################################
// bpu_ras: circular return address stack
// CALL corrections push pc+4, RET corrections pop
// ######################################################################
`timescale 1ns/100ps

module bpu_ras #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        corr_valid_i,
    input  bpu_pkg::correct_info_t      corr_info_i,
    output logic [31:0]                 ras_top_o
);

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [31:0]      stack_q [RAS_DEPTH];
    logic [PTR_W-1:0] top_q;      // points at top element
    logic [PTR_W-1:0] top_inc;
    logic [PTR_W-1:0] top_dec;
    logic             push;
    logic             pop;

    // wrap at RAS_DEPTH, also for non power of two
    assign top_inc = (top_q == PTR_W'(RAS_DEPTH - 1)) ? '0 : top_q + 1'b1;
    assign top_dec = (top_q == '0) ? PTR_W'(RAS_DEPTH - 1) : top_q - 1'b1;

    assign push = corr_valid_i && (corr_info_i.br_type == bpu_pkg::CALL);
    assign pop  = corr_valid_i && (corr_info_i.br_type == bpu_pkg::RET);

    assign ras_top_o = stack_q[top_q];  // empty stack gives old contents

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= PTR_W'(RAS_DEPTH - 1);  // first push lands in 0
        end else if (push) begin
            top_q <= top_inc;
        end else if (pop) begin
            top_q <= top_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[top_inc] <= corr_info_i.pc + 32'd4;  // return address
        end
    end

endmodule

//--- design/bpu_top.sv
// ######################################################################
// bpu_top: branch prediction unit, one fetch packet per cycle
// pc stage, BTB, local predictor, RAS and output register
// ######################################################################
`timescale 1ns/100ps

module bpu_top #(
    parameter logic [31:0] INIT_PC   = 32'h1c00_0000,
    parameter int          BTB_IDX_W = 8,
    parameter int          TAG_W     = 12,
    parameter int          HIST_W    = 5,
    parameter int          PHT_PC_W  = 8,
    parameter int          RAS_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        corr_valid_i,
    input  bpu_pkg::correct_info_t      corr_info_i,
    input  logic                        pred_ready_i,
    output logic                        pred_valid_o,
    output bpu_pkg::predict_info_t      pred_info_o
);

    logic [31:0]               pc;
    bpu_pkg::btb_entry_t [1:0] btb_slot;
    logic [1:0]                hit;
    bpu_pkg::scnt_t [1:0]      scnt;
    logic [31:0]               ras_top;
    bpu_pkg::predict_info_t    pred;
    logic                      accept;
    logic                      flush;

    assign flush = corr_valid_i & corr_info_i.mispredict;  // mispredict strobe

    bpu_pc_stage #(.INIT_PC(INIT_PC)) u_pc_stage (
        .clk(clk), .rst_n(rst_n), .accept_i(accept),
        .corr_valid_i(corr_valid_i), .corr_info_i(corr_info_i),
        .btb_slot_i(btb_slot), .hit_i(hit), .scnt_i(scnt), .ras_top_i(ras_top),
        .pc_o(pc), .pred_o(pred)
    );

    bpu_btb #(.BTB_IDX_W(BTB_IDX_W), .TAG_W(TAG_W)) u_btb (
        .clk(clk), .rst_n(rst_n), .lookup_pc_i(pc),
        .corr_valid_i(corr_valid_i), .corr_info_i(corr_info_i),
        .btb_slot_o(btb_slot), .hit_o(hit)
    );

    bpu_local_predictor #(
        .BTB_IDX_W(BTB_IDX_W), .HIST_W(HIST_W), .PHT_PC_W(PHT_PC_W)
    ) u_local_predictor (
        .clk(clk), .rst_n(rst_n), .lookup_pc_i(pc),
        .corr_valid_i(corr_valid_i), .corr_info_i(corr_info_i), .scnt_o(scnt)
    );

    bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst_n(rst_n),
        .corr_valid_i(corr_valid_i), .corr_info_i(corr_info_i), .ras_top_o(ras_top)
    );

    bpu_out_stage u_out_stage (
        .clk(clk), .rst_n(rst_n), .pred_i(pred), .flush_i(flush),
        .pred_ready_i(pred_ready_i), .accept_o(accept),
        .pred_valid_o(pred_valid_o), .pred_info_o(pred_info_o)
    );

endmodule

//--- filelist.f
common/bpu_pkg.sv
design/bpu_btb.sv
design/bpu_local_predictor.sv
design/bpu_ras.sv
design/bpu_pc_stage.sv
design/bpu_out_stage.sv
design/bpu_top.sv
tb/bpu_sva.sv
tb/bpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module bpu_tb -f filelist.f -o bpu_sim > build.log 2>&1 \
    || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/bpu_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

//--- tb/bpu_sva.sv
// ######################################################################
// bpu_sva: assertions on the output register handshake
// reset value, stability under stall, flush clears valid
// ######################################################################
`timescale 1ns/100ps

module bpu_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   flush_i,
    input logic                   pred_ready_i,
    input logic                   pred_valid_o,
    input bpu_pkg::predict_info_t pred_info_o
);

    // valid low out of reset
    assert property (@(posedge clk) !rst_n |=> !pred_valid_o)
        else $error("pred_valid_o high after a reset cycle");

    // held packet must not move while stalled
    assert property (@(posedge clk) disable iff (!rst_n)
        (pred_valid_o && !pred_ready_i && !flush_i) |=> (pred_valid_o && $stable(pred_info_o)))
        else $error("pred_info_o changed under back-pressure");

    // flushed packet is gone the next cycle
    assert property (@(posedge clk) disable iff (!rst_n) flush_i |=> !pred_valid_o)
        else $error("pred_valid_o high right after a flush");

endmodule

bind bpu_out_stage bpu_sva u_bpu_sva (
    .clk(clk),
    .rst_n(rst_n),
    .flush_i(flush_i),
    .pred_ready_i(pred_ready_i),
    .pred_valid_o(pred_valid_o),
    .pred_info_o(pred_info_o)
);

//--- tb/bpu_tb.sv
// ######################################################################
// bpu_tb: testbench for the branch prediction unit
// table of trainings and probes, local history model, handshake tests
// ######################################################################
`timescale 1ns/100ps

module bpu_tb;

    localparam logic [31:0] INIT_PC = 32'h1c00_0000;
    localparam int          MAX_ROWS = 32;

    logic                   clk;
    logic                   rst_n;
    logic                   corr_valid_i;
    bpu_pkg::correct_info_t corr_info_i;
    logic                   pred_ready_i;
    logic                   pred_valid_o;
    bpu_pkg::predict_info_t pred_info_o;

    // scenario table, kind 0 = training correction, 1 = probe
    logic                 r_kind   [MAX_ROWS];
    logic [31:0]          r_pc     [MAX_ROWS];
    bpu_pkg::br_type_e    r_type   [MAX_ROWS];  // trained type, or expected type
    logic [31:0]          r_target [MAX_ROWS];
    logic                 r_taken  [MAX_ROWS];  // trained dir, or expected taken
    int                   r_cnt    [MAX_ROWS];  // repeat count of a training
    logic [31:0]          r_npc    [MAX_ROWS];
    logic                 r_slot   [MAX_ROWS];
    logic [1:0]           r_mask   [MAX_ROWS];
    int                   n_rows;

    // local history reference, keyed by branch pc
    logic [4:0]  hist_m  [logic [31:0]];
    logic [1:0]  cnt_m   [logic [31:0]];  // keyed by {slot, hist, pc bits}
    bit          cond_m  [logic [31:0]];

    int          errors;
    int          checks;
    bit          timed_out;
    logic [31:0] prev_npc;
    int          n_xfer;

    bpu_top #(.INIT_PC(INIT_PC)) u_bpu_top (
        .clk(clk), .rst_n(rst_n),
        .corr_valid_i(corr_valid_i), .corr_info_i(corr_info_i),
        .pred_ready_i(pred_ready_i),
        .pred_valid_o(pred_valid_o), .pred_info_o(pred_info_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic add_train(input logic [31:0] pc, input bpu_pkg::br_type_e t,
                             input logic [31:0] target, input logic taken, input int cnt);
        r_kind[n_rows]   = 1'b0;
        r_pc[n_rows]     = pc;
        r_type[n_rows]   = t;
        r_target[n_rows] = target;
        r_taken[n_rows]  = taken;
        r_cnt[n_rows]    = cnt;
        n_rows++;
    endtask

    task automatic add_probe(input logic [31:0] pc, input logic [31:0] npc, input logic taken,
                             input logic slot, input logic [1:0] mask,
                             input bpu_pkg::br_type_e t);
        r_kind[n_rows]  = 1'b1;
        r_pc[n_rows]    = pc;
        r_npc[n_rows]   = npc;
        r_taken[n_rows] = taken;
        r_slot[n_rows]  = slot;
        r_mask[n_rows]  = mask;
        r_type[n_rows]  = t;
        n_rows++;
    endtask

    // one cycle strobe, starting at a falling edge
    task automatic send_corr(input logic [31:0] pc, input bpu_pkg::br_type_e t,
                             input logic [31:0] target, input logic taken,
                             input logic mispredict, input logic [31:0] redirect_pc);
        @(negedge clk);
        corr_info_i.pc          = pc;
        corr_info_i.target      = target;
        corr_info_i.br_type     = t;
        corr_info_i.taken       = taken;
        corr_info_i.mispredict  = mispredict;
        corr_info_i.redirect_pc = redirect_pc;
        corr_valid_i            = 1'b1;
        @(negedge clk);
        corr_valid_i = 1'b0;
    endtask

    // saturating counter step and history shift of the model
    task automatic model_train(input logic [31:0] pc, input logic taken);
        logic [4:0]  h;
        logic [31:0] key;
        logic [1:0]  c;
        h   = hist_m.exists(pc) ? hist_m[pc] : 5'd0;
        key = {18'd0, pc[2], h, pc[10:3]};
        c   = cnt_m.exists(key) ? cnt_m[key] : 2'd0;
        if (taken && c != 2'd3) c = c + 2'd1;
        else if (!taken && c != 2'd0) c = c - 2'd1;
        cnt_m[key]  = c;
        hist_m[pc]  = {h[3:0], taken};
        cond_m[pc]  = 1'b1;
    endtask

    function automatic logic model_taken(input logic [31:0] pc);
        logic [4:0]  h;
        logic [31:0] key;
        h   = hist_m.exists(pc) ? hist_m[pc] : 5'd0;
        key = {18'd0, pc[2], h, pc[10:3]};
        return cnt_m.exists(key) ? cnt_m[key][1] : 1'b0;
    endfunction

    task automatic wait_valid(input string what);
        int n;
        n = 0;
        while (!pred_valid_o && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!pred_valid_o) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: no valid packet arrived for %s", what);
        end
    endtask

    task automatic run_row(input int r);
        if (r_kind[r] == 1'b0) begin
            for (int k = 0; k < r_cnt[r]; k++) begin
                send_corr(r_pc[r], r_type[r], r_target[r], r_taken[r], 1'b0, 32'd0);
                if (r_type[r] == bpu_pkg::COND) model_train(r_pc[r], r_taken[r]);
            end
        end else begin
            if (cond_m.exists(r_pc[r]))
                check_val("model_taken", 32'(model_taken(r_pc[r])), 32'(r_taken[r]));
            send_corr(32'd0, bpu_pkg::NONE, 32'd0, 1'b0, 1'b1, r_pc[r]);  // redirect to probe
            wait_valid("probe");
            if (!timed_out) begin
                check_val("pred_info_o.pc", pred_info_o.pc, r_pc[r]);
                check_val("pred_info_o.npc", pred_info_o.npc, r_npc[r]);
                check_val("pred_info_o.taken", 32'(pred_info_o.taken), 32'(r_taken[r]));
                check_val("pred_info_o.mask", 32'(pred_info_o.mask), 32'(r_mask[r]));
                check_val("pred_info_o.br_type", 32'(pred_info_o.br_type), 32'(r_type[r]));
                if (r_taken[r])
                    check_val("pred_info_o.taken_slot", 32'(pred_info_o.taken_slot),
                              32'(r_slot[r]));
            end
        end
    endtask

    task automatic fill_table;
        n_rows = 0;
        // odd slot start
        add_probe(32'h1c00_0104, 32'h1c00_0108, 1'b0, 1'b0, 2'b10, bpu_pkg::NONE);
        add_train(32'h1c00_1000, bpu_pkg::JUMP, 32'h1c00_2000, 1'b1, 1);
        add_probe(32'h1c00_1000, 32'h1c00_2000, 1'b1, 1'b0, 2'b01, bpu_pkg::JUMP);
        add_train(32'h1c00_1104, bpu_pkg::JUMP, 32'h1c00_3000, 1'b1, 1);
        add_probe(32'h1c00_1100, 32'h1c00_3000, 1'b1, 1'b1, 2'b11, bpu_pkg::JUMP);
        add_probe(32'h1c00_1104, 32'h1c00_3000, 1'b1, 1'b1, 2'b10, bpu_pkg::JUMP);
        add_train(32'h1c00_1004, bpu_pkg::JUMP, 32'h1c00_4000, 1'b1, 1);
        add_probe(32'h1c00_1000, 32'h1c00_2000, 1'b1, 1'b0, 2'b01, bpu_pkg::JUMP);  // slot 0 wins
        // conditional, history saturates at all ones before the counter climbs
        add_train(32'h1c00_5000, bpu_pkg::COND, 32'h1c00_6000, 1'b0, 1);
        add_probe(32'h1c00_5000, 32'h1c00_5008, 1'b0, 1'b0, 2'b11, bpu_pkg::NONE);
        add_train(32'h1c00_5000, bpu_pkg::COND, 32'h1c00_6000, 1'b1, 6);
        add_probe(32'h1c00_5000, 32'h1c00_5008, 1'b0, 1'b0, 2'b11, bpu_pkg::NONE);
        add_train(32'h1c00_5000, bpu_pkg::COND, 32'h1c00_6000, 1'b1, 1);
        add_probe(32'h1c00_5000, 32'h1c00_6000, 1'b1, 1'b0, 2'b01, bpu_pkg::COND);
        add_train(32'h1c00_5000, bpu_pkg::COND, 32'h1c00_6000, 1'b0, 1);
        add_probe(32'h1c00_5000, 32'h1c00_5008, 1'b0, 1'b0, 2'b11, bpu_pkg::NONE);
        // return stack, ret trained first so its pop precedes the call
        add_train(32'h1c00_8040, bpu_pkg::RET, 32'h0, 1'b1, 1);
        add_train(32'h1c00_7010, bpu_pkg::CALL, 32'h1c00_8040, 1'b1, 1);
        add_probe(32'h1c00_8040, 32'h1c00_7014, 1'b1, 1'b0, 2'b01, bpu_pkg::RET);
        add_train(32'h1c00_9020, bpu_pkg::CALL, 32'h1c00_8040, 1'b1, 1);
        add_train(32'h1c00_a030, bpu_pkg::CALL, 32'h1c00_8040, 1'b1, 1);
        add_probe(32'h1c00_8040, 32'h1c00_a034, 1'b1, 1'b0, 2'b01, bpu_pkg::RET);
        add_train(32'h1c00_8040, bpu_pkg::RET, 32'h0, 1'b1, 1);
        add_probe(32'h1c00_8040, 32'h1c00_9024, 1'b1, 1'b0, 2'b01, bpu_pkg::RET);
    endtask

    initial begin
        void'($urandom(32'h3ea6_3fbf));
        rst_n        = 1'b0;
        corr_valid_i = 1'b0;
        corr_info_i  = '0;
        pred_ready_i = 1'b1;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        fill_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        wait_valid("first packet after reset");
        if (!timed_out) begin
            check_val("pred_info_o.pc", pred_info_o.pc, INIT_PC);
            check_val("pred_info_o.npc", pred_info_o.npc, INIT_PC + 32'd8);
            check_val("pred_info_o.mask", 32'(pred_info_o.mask), 32'h3);
            check_val("pred_info_o.taken", 32'(pred_info_o.taken), 32'h0);
            check_val("pred_info_o.br_type", 32'(pred_info_o.br_type), 32'(bpu_pkg::NONE));
        end

        for (int r = 0; r < n_rows; r++) begin
            if (!timed_out) run_row(r);
        end

        // random back-pressure, accepted packets must chain by npc
        if (!timed_out) begin
            send_corr(32'd0, bpu_pkg::NONE, 32'd0, 1'b0, 1'b1, 32'h1c00_1100);
            prev_npc = 32'h1c00_1100;
            n_xfer   = 0;
            for (int c = 0; c < 80; c++) begin
                pred_ready_i = ($urandom % 4) != 0;
                if (pred_valid_o && pred_ready_i) begin
                    check_val("chain pred_info_o.pc", pred_info_o.pc, prev_npc);
                    prev_npc = pred_info_o.npc;
                    n_xfer++;
                end
                @(negedge clk);
            end
            if (n_xfer < 20) begin
                errors++;
                $display("too few packets accepted under back-pressure: %0d", n_xfer);
            end
        end

        // mispredict while stalled drops the held packet
        if (!timed_out) begin
            pred_ready_i = 1'b0;
            wait_valid("stalled packet");
        end
        if (!timed_out) begin
            send_corr(32'd0, bpu_pkg::NONE, 32'd0, 1'b0, 1'b1, 32'h1c00_c000);
            pred_ready_i = 1'b1;
            wait_valid("packet after redirect");
            if (!timed_out) check_val("redirect pred_info_o.pc", pred_info_o.pc, 32'h1c00_c000);
        end

        $display("errors %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
